// ==== msi_ptw.f ====
+incdir+hdl
hdl/msi_ptw_pkg.sv
hdl/pte_chk_if.sv
hdl/msi_cfg_regs.sv
hdl/msi_imsic_extract.sv
hdl/msi_pte_check.sv
hdl/msi_walk_fsm.sv
hdl/msi_ptw_top.sv
tests/msi_ptw_properties.sv
tests/msi_ptw_tb.sv

// ==== Makefile ====
VERILATOR  := verilator
SIM_FLAGS  := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing
TOP        := msi_ptw_tb
FILELIST   := msi_ptw.f
OBJ_DIR    := obj_dir
PASS_MSG   := TEST RESULT: PASS

.PHONY: lint build sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== tests/msi_ptw_tb.sv ====
`timescale 1ns/1ps
`include "msi_ptw_params.svh"

module msi_ptw_tb
    import msi_ptw_pkg::*;
();

    localparam int WAIT_LIMIT = 50;

    logic                    clk_i;
    logic                    rst_ni;
    logic                    cfg_we_i;
    cfg_sel_e                cfg_sel_i;
    logic [`MSI_DATA_W-1:0]  cfg_wdata_i;
    logic                    init_i;
    logic [`MSI_GPLEN-1:0]   iova_i;
    logic [`MSI_GSCID_W-1:0] gscid_i;
    logic                    is_rx_i;
    logic                    ar_valid_o;
    logic                    ar_ready_i;
    logic [`MSI_PLEN-1:0]    ar_addr_o;
    logic                    r_valid_i;
    logic [`MSI_DATA_W-1:0]  r_data_i;
    axi_resp_e               r_resp_i;
    logic                    r_last_i;
    logic                    iotlb_update_o;
    logic [`MSI_PPNW-1:0]    iotlb_ppn_o;
    logic [`MSI_GPPNW-1:0]   iotlb_vpn_o;
    logic [`MSI_GSCID_W-1:0] iotlb_gscid_o;
    logic                    error_o;
    msi_cause_e              cause_o;
    logic                    active_o;

    // Score and per-walk observations
    int                      checks;
    int                      errors;
    int                      upd_cnt;
    int                      err_cycles;
    int                      ar_cycles;
    int                      act_cycles;
    logic [`MSI_PPNW-1:0]    got_ppn;
    logic [`MSI_GPPNW-1:0]   got_vpn;
    logic [`MSI_GSCID_W-1:0] got_gscid;
    msi_cause_e              got_cause;
    // Mirror of the config registers
    logic [`MSI_PPNW-1:0]    cur_base;
    logic [`MSI_MASK_W-1:0]  cur_mask;

    msi_ptw_top dut (.*);

    always #50 clk_i = ~clk_i;

    task automatic check_ppn(input string name, input logic [`MSI_PPNW-1:0] exp,
                             input logic [`MSI_PPNW-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAIL %s: expected ppn %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_vpn(input string name, input logic [`MSI_GPPNW-1:0] exp,
                             input logic [`MSI_GPPNW-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAIL %s: expected vpn %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_gscid(input string name, input logic [`MSI_GSCID_W-1:0] exp,
                               input logic [`MSI_GSCID_W-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAIL %s: expected gscid %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_addr(input string name, input logic [`MSI_PLEN-1:0] exp,
                              input logic [`MSI_PLEN-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAIL %s: expected address %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_cause(input string name, input msi_cause_e exp, input msi_cause_e act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAIL %s: expected cause %s, actual %s (%0d)", name, exp.name(),
                     act.name(), act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAIL %s: expected bit %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        checks++;
        if (act != exp) begin
            errors++;
            $display("FAIL %s: expected count %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic end_on_timeout(input string what);
        errors++;
        $display("Timeout: gave up waiting for %s", what);
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("TEST RESULT: FAIL");
        $finish;
    endtask

    // Packs the first PTE beat field by field
    function automatic logic [63:0] make_pte(input logic v, input logic [1:0] m,
                                             input logic [`MSI_PPNW-1:0] ppn,
                                             input logic [6:0] rsv_lo, input logic [8:0] rsv_hi,
                                             input logic c);
        logic [63:0] w;
        w        = '0;
        w[0]     = v;
        w[2:1]   = m;
        w[9:3]   = rsv_lo;
        w[53:10] = ppn;
        w[62:54] = rsv_hi;
        w[63]    = c;
        return w;
    endfunction

    // Scan from the top so the lowest selected bit ends at bit 0
    function automatic logic [`MSI_GPPNW-1:0] gather_bits(input logic [`MSI_GPPNW-1:0] gppn,
                                                          input logic [`MSI_MASK_W-1:0] mask);
        logic [`MSI_GPPNW-1:0] res;
        res = '0;
        for (int b = `MSI_MASK_W - 1; b >= 0; b--) begin
            if (mask[b]) begin
                res = {res[`MSI_GPPNW-2:0], gppn[b]};
            end
        end
        return res;
    endfunction

    function automatic logic [`MSI_PLEN-1:0] pte_addr(input logic [`MSI_GPLEN-1:0] iova);
        logic [`MSI_PLEN-1:0] hi;
        logic [`MSI_PLEN-1:0] lo;
        hi = '0;
        lo = '0;
        hi[`MSI_PLEN-1:`MSI_PAGE_SHIFT] = cur_base;
        lo[`MSI_GPPNW+`MSI_PTE_SHIFT-1:`MSI_PTE_SHIFT] =
            gather_bits(iova[`MSI_GPLEN-1:`MSI_PAGE_SHIFT], cur_mask);
        return hi | lo;
    endfunction

    function automatic logic [`MSI_PPNW-1:0] rand_ppn();
        logic [63:0] r;
        r = {$urandom, $urandom};
        return r[`MSI_PPNW-1:0];
    endfunction

    task automatic clear_counts();
        upd_cnt    = 0;
        err_cycles = 0;
        ar_cycles  = 0;
        act_cycles = 0;
    endtask

    // Outputs are stable at the falling edge
    task automatic observe();
        @(negedge clk_i);
        if (iotlb_update_o) begin
            upd_cnt++;
            got_ppn   = iotlb_ppn_o;
            got_vpn   = iotlb_vpn_o;
            got_gscid = iotlb_gscid_o;
        end
        if (error_o) begin
            err_cycles++;
            got_cause = cause_o;
        end
        if (ar_valid_o) begin
            ar_cycles++;
        end
        if (active_o) begin
            act_cycles++;
        end
    endtask

    task automatic write_cfg(input cfg_sel_e sel, input logic [63:0] data);
        @(posedge clk_i);
        cfg_we_i    <= 1'b1;
        cfg_sel_i   <= sel;
        cfg_wdata_i <= data;
        @(posedge clk_i);
        cfg_we_i <= 1'b0;
        // Registers keep only their low bits
        if (sel == CFG_MSIPTP) begin
            cur_base = data[`MSI_PPNW-1:0];
        end else begin
            cur_mask = data[`MSI_MASK_W-1:0];
        end
    endtask

    // Walker is idle here, so the second edge accepts
    task automatic start_request(input logic [`MSI_GPLEN-1:0] iova,
                                 input logic [`MSI_GSCID_W-1:0] gscid, input logic is_rx);
        @(posedge clk_i);
        init_i  <= 1'b1;
        iova_i  <= iova;
        gscid_i <= gscid;
        is_rx_i <= is_rx;
        @(posedge clk_i);
        init_i  <= 1'b0;
        is_rx_i <= 1'b0;
        observe();
    endtask

    // Memory model, two beats with an optional gap
    task automatic respond(input logic [63:0] beat0, input axi_resp_e resp, input int gap);
        r_valid_i <= 1'b1;
        r_data_i  <= beat0;
        r_resp_i  <= resp;
        r_last_i  <= 1'b0;
        observe();
        repeat (gap) begin
            @(posedge clk_i);
            r_valid_i <= 1'b0;
            observe();
        end
        @(posedge clk_i);
        r_valid_i <= 1'b1;
        r_data_i  <= {$urandom, $urandom};
        r_last_i  <= 1'b1;
        observe();
        @(posedge clk_i);
        r_valid_i <= 1'b0;
        r_last_i  <= 1'b0;
        r_resp_i  <= RESP_OKAY;
    endtask

    task automatic wait_idle();
        int t;
        t = 0;
        observe();
        while (active_o) begin
            @(posedge clk_i);
            observe();
            t++;
            if (t > WAIT_LIMIT) begin
                end_on_timeout("active_o to fall after the last beat");
            end
        end
    endtask

    task automatic run_walk(input string name, input logic [`MSI_GPLEN-1:0] iova,
                            input logic [`MSI_GSCID_W-1:0] gscid, input logic [63:0] beat0,
                            input logic [`MSI_PPNW-1:0] exp_ppn, input axi_resp_e resp,
                            input int gap, input int ready_dly, input msi_cause_e exp_cause);
        logic [`MSI_PLEN-1:0] exp_addr;
        int                   t;
        exp_addr = pte_addr(iova);
        clear_counts();
        start_request(iova, gscid, 1'b0);
        t = 0;
        while (!ar_valid_o) begin
            @(posedge clk_i);
            observe();
            t++;
            if (t > WAIT_LIMIT) begin
                end_on_timeout("ar_valid_o");
            end
        end
        check_addr(name, exp_addr, ar_addr_o);
        // Stall the read address, request must hold
        repeat (ready_dly) begin
            @(posedge clk_i);
            observe();
            check_bit(name, 1'b1, ar_valid_o);
            check_addr(name, exp_addr, ar_addr_o);
        end
        @(posedge clk_i);
        ar_ready_i <= 1'b1;
        observe();
        @(posedge clk_i);
        ar_ready_i <= 1'b0;
        respond(beat0, resp, gap);
        wait_idle();
        check_count(name, ready_dly + 2, ar_cycles);
        // Busy from acceptance until the edge that takes the last beat
        check_count(name, ready_dly + gap + 4, act_cycles);
        if (exp_cause == CAUSE_NONE) begin
            check_count(name, 1, upd_cnt);
            check_count(name, 0, err_cycles);
            check_ppn(name, exp_ppn, got_ppn);
            check_vpn(name, iova[`MSI_GPLEN-1:`MSI_PAGE_SHIFT], got_vpn);
            check_gscid(name, gscid, got_gscid);
        end else begin
            // Fault holds from the beat after the first up to the last beat
            check_count(name, 0, upd_cnt);
            check_count(name, gap + 1, err_cycles);
            check_cause(name, exp_cause, got_cause);
        end
    endtask

    task automatic test_flat_success();
        logic [`MSI_PPNW-1:0] ppn;
        write_cfg(CFG_MSIPTP, 64'hFFF0_0000_0ABC_DEF1);
        write_cfg(CFG_ADDR_MASK, 64'hFFFF_FFFF_0000_0A35);
        ppn = rand_ppn();
        run_walk("flat_success", 41'h1AB_CDEF_1234, 16'hBEEF,
                 make_pte(1'b1, MODE_FLAT, ppn, 7'h0, 9'h0, 1'b0), ppn, RESP_OKAY, 0, 0,
                 CAUSE_NONE);
        write_cfg(CFG_ADDR_MASK, 64'h0000_0000_1F00_00F0);
        ppn = rand_ppn();
        run_walk("flat_success_gap", 41'h0F0_0F0F_5ABC, 16'h0042,
                 make_pte(1'b1, MODE_FLAT, ppn, 7'h0, 9'h0, 1'b0), ppn, RESP_OKAY, 2, 0,
                 CAUSE_NONE);
    endtask

    task automatic test_read_exec();
        clear_counts();
        start_request(41'h1AB_CDEF_1234, 16'h0007, 1'b1);
        check_bit("read_exec", 1'b1, error_o);
        check_cause("read_exec", CAUSE_INSTR_ACCESS, cause_o);
        repeat (3) begin
            @(posedge clk_i);
            observe();
        end
        check_count("read_exec", 1, err_cycles);
        check_count("read_exec", 0, ar_cycles);
        check_bit("read_exec", 1'b0, active_o);
    endtask

    task automatic test_invalid_pte();
        logic [`MSI_PPNW-1:0] ppn;
        ppn = rand_ppn();
        run_walk("invalid_v", 41'h055_1234_5678, 16'h0101,
                 make_pte(1'b0, MODE_FLAT, ppn, 7'h0, 9'h0, 1'b0), ppn, RESP_OKAY, 2, 0,
                 CAUSE_PTE_INVALID);
        run_walk("invalid_c", 41'h1FF_0000_1000, 16'h0202,
                 make_pte(1'b1, MODE_FLAT, ppn, 7'h0, 9'h0, 1'b1), ppn, RESP_OKAY, 1, 0,
                 CAUSE_PTE_INVALID);
    endtask

    task automatic test_misconfig();
        logic [`MSI_PPNW-1:0] ppn;
        ppn = rand_ppn();
        run_walk("misconfig_mrif", 41'h012_3456_7000, 16'h0303,
                 make_pte(1'b1, MODE_MRIF, ppn, 7'h0, 9'h0, 1'b0), ppn, RESP_OKAY, 0, 0,
                 CAUSE_PTE_MISCONFIG);
        run_walk("misconfig_mode", 41'h012_3456_7000, 16'h0303,
                 make_pte(1'b1, 2'd2, ppn, 7'h0, 9'h0, 1'b0), ppn, RESP_OKAY, 0, 0,
                 CAUSE_PTE_MISCONFIG);
        run_walk("misconfig_rsv_lo", 41'h012_3456_7000, 16'h0303,
                 make_pte(1'b1, MODE_FLAT, ppn, 7'h10, 9'h0, 1'b0), ppn, RESP_OKAY, 1, 0,
                 CAUSE_PTE_MISCONFIG);
        run_walk("misconfig_rsv_hi", 41'h012_3456_7000, 16'h0303,
                 make_pte(1'b1, MODE_FLAT, ppn, 7'h0, 9'h100, 1'b0), ppn, RESP_OKAY, 0, 0,
                 CAUSE_PTE_MISCONFIG);
    endtask

    task automatic test_bad_resp();
        logic [`MSI_PPNW-1:0] ppn;
        ppn = rand_ppn();
        run_walk("bad_resp", 41'h0AA_5555_3000, 16'h0404,
                 make_pte(1'b1, MODE_FLAT, ppn, 7'h0, 9'h0, 1'b0), ppn, RESP_SLVERR, 1, 0,
                 CAUSE_DATA_CORRUPT);
    endtask

    task automatic test_backpressure();
        logic [`MSI_PPNW-1:0] ppn;
        int                   dly;
        for (int i = 0; i < 3; i++) begin
            ppn = rand_ppn();
            dly = int'($urandom_range(6, 1));
            run_walk("backpressure", 41'h133_7000_0000 + 41'(i * 4096), 16'h0500,
                     make_pte(1'b1, MODE_FLAT, ppn, 7'h0, 9'h0, 1'b0), ppn, RESP_OKAY, i, dly,
                     CAUSE_NONE);
        end
    endtask

    initial begin
        void'($urandom(44));
        checks      = 0;
        errors      = 0;
        cur_base    = '0;
        cur_mask    = '0;
        clk_i       = 1'b0;
        rst_ni      <= 1'b0;
        cfg_we_i    <= 1'b0;
        cfg_sel_i   <= CFG_MSIPTP;
        cfg_wdata_i <= '0;
        init_i      <= 1'b0;
        iova_i      <= '0;
        gscid_i     <= '0;
        is_rx_i     <= 1'b0;
        ar_ready_i  <= 1'b0;
        r_valid_i   <= 1'b0;
        r_data_i    <= '0;
        r_resp_i    <= RESP_OKAY;
        r_last_i    <= 1'b0;
        repeat (4) @(posedge clk_i);
        rst_ni <= 1'b1;
        clear_counts();
        observe();
        // Quiet outputs out of reset
        check_bit("reset", 1'b0, ar_valid_o);
        check_bit("reset", 1'b0, iotlb_update_o);
        check_bit("reset", 1'b0, error_o);
        check_bit("reset", 1'b0, active_o);
        test_flat_success();
        test_read_exec();
        test_invalid_pte();
        test_misconfig();
        test_bad_resp();
        test_backpressure();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== tests/msi_ptw_properties.sv ====
`timescale 1ns/1ps
`include "msi_ptw_params.svh"

module msi_ptw_properties (
    input logic                 clk_i,
    input logic                 rst_ni,
    input logic                 ar_valid_o,
    input logic                 ar_ready_i,
    input logic [`MSI_PLEN-1:0] ar_addr_o,
    input logic                 iotlb_update_o,
    input logic                 error_o,
    input logic                 active_o
);

    // Read request held until the handshake
    property ar_hold_p;
        @(posedge clk_i) disable iff (!rst_ni)
            (ar_valid_o && !ar_ready_i) |=> (ar_valid_o && $stable(ar_addr_o));
    endproperty

    ar_hold_a: assert property (ar_hold_p)
        else $error("read address dropped or changed before ar_ready_i");

    // Update and fault are exclusive
    excl_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(iotlb_update_o && error_o))
        else $error("iotlb_update_o and error_o high together");

    // A fault only while a walk is running
    err_active_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        error_o |-> active_o)
        else $error("error_o high while walker idle");

endmodule

bind msi_ptw_top msi_ptw_properties u_properties (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .ar_valid_o     (ar_valid_o),
    .ar_ready_i     (ar_ready_i),
    .ar_addr_o      (ar_addr_o),
    .iotlb_update_o (iotlb_update_o),
    .error_o        (error_o),
    .active_o       (active_o)
);

// ==== hdl/msi_ptw_top.sv ====
`timescale 1ns/1ps
`include "msi_ptw_params.svh"

module msi_ptw_top
    import msi_ptw_pkg::*;
(
    input  logic                    clk_i,
    input  logic                    rst_ni,
    // Config write
    input  logic                    cfg_we_i,
    input  cfg_sel_e                cfg_sel_i,
    input  logic [`MSI_DATA_W-1:0]  cfg_wdata_i,
    // Translation request
    input  logic                    init_i,
    input  logic [`MSI_GPLEN-1:0]   iova_i,
    input  logic [`MSI_GSCID_W-1:0] gscid_i,
    input  logic                    is_rx_i,
    // Read address channel
    output logic                    ar_valid_o,
    input  logic                    ar_ready_i,
    output logic [`MSI_PLEN-1:0]    ar_addr_o,
    // Read data channel
    input  logic                    r_valid_i,
    input  logic [`MSI_DATA_W-1:0]  r_data_i,
    input  axi_resp_e               r_resp_i,
    input  logic                    r_last_i,
    // IOTLB update
    output logic                    iotlb_update_o,
    output logic [`MSI_PPNW-1:0]    iotlb_ppn_o,
    output logic [`MSI_GPPNW-1:0]   iotlb_vpn_o,
    output logic [`MSI_GSCID_W-1:0] iotlb_gscid_o,
    // Fault and status
    output logic                    error_o,
    output msi_cause_e              cause_o,
    output logic                    active_o
);

    logic [`MSI_PPNW-1:0]   msiptp_ppn;
    logic [`MSI_MASK_W-1:0] addr_mask;
    logic [`MSI_GPPNW-1:0]  gppn;
    logic [`MSI_GPPNW-1:0]  imsic_num;

    pte_chk_if chk_if ();

    msi_cfg_regs u_cfg_regs (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .cfg_we_i     (cfg_we_i),
        .cfg_sel_i    (cfg_sel_i),
        .cfg_wdata_i  (cfg_wdata_i),
        .msiptp_ppn_o (msiptp_ppn),
        .addr_mask_o  (addr_mask)
    );

    msi_imsic_extract u_imsic_extract (
        .gppn_i      (gppn),
        .mask_i      (addr_mask),
        .imsic_num_o (imsic_num)
    );

    msi_walk_fsm u_walk_fsm (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .init_i         (init_i),
        .iova_i         (iova_i),
        .gscid_i        (gscid_i),
        .is_rx_i        (is_rx_i),
        .msiptp_ppn_i   (msiptp_ppn),
        .imsic_num_i    (imsic_num),
        .gppn_o         (gppn),
        .ar_valid_o     (ar_valid_o),
        .ar_ready_i     (ar_ready_i),
        .ar_addr_o      (ar_addr_o),
        .r_valid_i      (r_valid_i),
        .r_data_i       (r_data_i),
        .r_resp_i       (r_resp_i),
        .r_last_i       (r_last_i),
        .iotlb_update_o (iotlb_update_o),
        .iotlb_ppn_o    (iotlb_ppn_o),
        .iotlb_vpn_o    (iotlb_vpn_o),
        .iotlb_gscid_o  (iotlb_gscid_o),
        .error_o        (error_o),
        .cause_o        (cause_o),
        .active_o       (active_o),
        .chk            (chk_if.fsm)
    );

    msi_pte_check u_pte_check (
        .chk (chk_if.chk)
    );

endmodule

// ==== hdl/msi_walk_fsm.sv ====
`timescale 1ns/1ps
`include "msi_ptw_params.svh"

module msi_walk_fsm
    import msi_ptw_pkg::*;
(
    input  logic                    clk_i,
    input  logic                    rst_ni,
    // Translation request
    input  logic                    init_i,
    input  logic [`MSI_GPLEN-1:0]   iova_i,
    input  logic [`MSI_GSCID_W-1:0] gscid_i,
    input  logic                    is_rx_i,
    // Configuration and extracted IMSIC number
    input  logic [`MSI_PPNW-1:0]    msiptp_ppn_i,
    input  logic [`MSI_GPPNW-1:0]   imsic_num_i,
    output logic [`MSI_GPPNW-1:0]   gppn_o,
    // Read address channel
    output logic                    ar_valid_o,
    input  logic                    ar_ready_i,
    output logic [`MSI_PLEN-1:0]    ar_addr_o,
    // Read data channel
    input  logic                    r_valid_i,
    input  logic [`MSI_DATA_W-1:0]  r_data_i,
    input  axi_resp_e               r_resp_i,
    input  logic                    r_last_i,
    // IOTLB update
    output logic                    iotlb_update_o,
    output logic [`MSI_PPNW-1:0]    iotlb_ppn_o,
    output logic [`MSI_GPPNW-1:0]   iotlb_vpn_o,
    output logic [`MSI_GSCID_W-1:0] iotlb_gscid_o,
    // Fault reporting and status
    output logic                    error_o,
    output msi_cause_e              cause_o,
    output logic                    active_o,
    // PTE checker
    pte_chk_if.fsm                  chk
);

    walk_state_e                state_q, state_n;
    msi_cause_e                 cause_q, cause_n;
    // Set once a faulty beat is seen before the last one
    logic                       wait_rlast_q, wait_rlast_n;
    logic                       accept;
    logic [`MSI_PLEN-1:0]       pptr_q;
    logic [`MSI_GPPNW-1:0]      vpn_q;
    logic [`MSI_GSCID_W-1:0]    gscid_q;

    // GPA page bits go straight to the extractor
    assign gppn_o = iova_i[`MSI_GPLEN-1:`MSI_PAGE_SHIFT];

    // Only one walk at a time
    assign accept = init_i && (state_q == ST_IDLE);

    // Live beat to the checker
    assign chk.pte  = msi_pte_flat_t'(r_data_i);
    assign chk.resp = r_resp_i;

    always_comb begin
        state_n        = state_q;
        cause_n        = cause_q;
        wait_rlast_n   = wait_rlast_q;
        iotlb_update_o = 1'b0;
        case (state_q)
            ST_IDLE: begin
                wait_rlast_n = 1'b0;
                if (accept) begin
                    // Fetch of an instruction from an MSI page faults at once
                    if (is_rx_i) begin
                        cause_n = CAUSE_INSTR_ACCESS;
                        state_n = ST_ERROR;
                    end else begin
                        state_n = ST_MEM_ACCESS;
                    end
                end
            end
            ST_MEM_ACCESS: begin
                if (ar_ready_i) begin
                    state_n = ST_PROC_PTE;
                end
            end
            ST_PROC_PTE: begin
                if (r_valid_i) begin
                    if (chk.fault) begin
                        cause_n      = chk.cause;
                        wait_rlast_n = !r_last_i;
                        state_n      = ST_ERROR;
                    end else begin
                        iotlb_update_o = 1'b1;
                        // Second beat still has to be consumed
                        state_n        = r_last_i ? ST_IDLE : ST_DRAIN;
                    end
                end
            end
            ST_DRAIN: begin
                if (r_valid_i && r_last_i) begin
                    state_n = ST_IDLE;
                end
            end
            ST_ERROR: begin
                // Hold the cause until the burst has ended
                if (!wait_rlast_q || (r_valid_i && r_last_i)) begin
                    state_n = ST_IDLE;
                end
            end
            default: begin
                state_n = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q      <= ST_IDLE;
            cause_q      <= CAUSE_NONE;
            wait_rlast_q <= 1'b0;
        end else begin
            state_q      <= state_n;
            cause_q      <= cause_n;
            wait_rlast_q <= wait_rlast_n;
        end
    end

    // Request tags and PTE address, captured on acceptance
    always_ff @(posedge clk_i) begin
        if (accept) begin
            pptr_q  <= {msiptp_ppn_i, {`MSI_PAGE_SHIFT{1'b0}}}
                     | ({{(`MSI_PLEN - `MSI_GPPNW){1'b0}}, imsic_num_i} << `MSI_PTE_SHIFT);
            vpn_q   <= gppn_o;
            gscid_q <= gscid_i;
        end
    end

    // Burst of two 8-byte beats is implied
    assign ar_valid_o = (state_q == ST_MEM_ACCESS);
    assign ar_addr_o  = pptr_q;

    // PPN taken from the beat being judged
    assign iotlb_ppn_o   = chk.pte.ppn;
    assign iotlb_vpn_o   = vpn_q;
    assign iotlb_gscid_o = gscid_q;

    assign error_o  = (state_q == ST_ERROR);
    assign cause_o  = error_o ? cause_q : CAUSE_NONE;
    assign active_o = (state_q != ST_IDLE);

endmodule

// ==== hdl/msi_pte_check.sv ====
`timescale 1ns/1ps

module msi_pte_check
    import msi_ptw_pkg::*;
(
    pte_chk_if.chk chk
);

    // Individual checks on the beat
    logic pte_invalid;
    logic resp_bad;
    logic mode_bad;
    logic rsv_set;

    // V clear, or a custom format flagged by C
    assign pte_invalid = !chk.pte.v || chk.pte.c;

    // Anything but OKAY counts as corrupted data
    assign resp_bad = (chk.resp != RESP_OKAY);

    // MRIF is unsupported here, treated like a reserved mode
    assign mode_bad = (chk.pte.m != MODE_FLAT);
    assign rsv_set  = (|chk.pte.rsv_lo) || (|chk.pte.rsv_hi);

    // Priority order of the checks matters
    always_comb begin
        chk.fault = 1'b1;
        if (pte_invalid) begin
            chk.cause = CAUSE_PTE_INVALID;
        end else if (resp_bad) begin
            chk.cause = CAUSE_DATA_CORRUPT;
        end else if (mode_bad || rsv_set) begin
            chk.cause = CAUSE_PTE_MISCONFIG;
        end else begin
            // Good flat PTE
            chk.fault = 1'b0;
            chk.cause = CAUSE_NONE;
        end
    end

endmodule

// ==== hdl/msi_imsic_extract.sv ====
`timescale 1ns/1ps
`include "msi_ptw_params.svh"

module msi_imsic_extract (
    // Guest page number of the request
    input  logic [`MSI_GPPNW-1:0]   gppn_i,
    // Bits that select the interrupt file
    input  logic [`MSI_MASK_W-1:0]  mask_i,
    // Packed interrupt file number
    output logic [`MSI_GPPNW-1:0]   imsic_num_o
);

    // Bit gather, like a parallel extract
    always_comb begin : gather
        logic [$clog2(`MSI_GPPNW)-1:0] k;
        imsic_num_o = '0;
        k           = '0;
        // Scan mask LSB first
        for (int i = 0; i < `MSI_MASK_W; i++) begin
            if (mask_i[i]) begin
                // Selected bit lands at the next free position
                imsic_num_o[k] = gppn_i[i];
                k              = k + 1'b1;
            end
        end
    end : gather

endmodule

// ==== hdl/msi_cfg_regs.sv ====
`timescale 1ns/1ps
`include "msi_ptw_params.svh"

module msi_cfg_regs
    import msi_ptw_pkg::*;
(
    input  logic                    clk_i,
    input  logic                    rst_ni,
    // Register write port
    input  logic                    cfg_we_i,
    input  cfg_sel_e                cfg_sel_i,
    input  logic [`MSI_DATA_W-1:0]  cfg_wdata_i,
    // Walk configuration
    output logic [`MSI_PPNW-1:0]    msiptp_ppn_o,
    output logic [`MSI_MASK_W-1:0]  addr_mask_o
);

    // MSI page table base and IMSIC number mask
    logic [`MSI_PPNW-1:0]   msiptp_ppn_q;
    logic [`MSI_MASK_W-1:0] addr_mask_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            msiptp_ppn_q <= '0;
            addr_mask_q  <= '0;
        end else if (cfg_we_i) begin
            // Upper write data bits are dropped
            case (cfg_sel_i)
                CFG_MSIPTP: begin
                    msiptp_ppn_q <= cfg_wdata_i[`MSI_PPNW-1:0];
                end
                CFG_ADDR_MASK: begin
                    addr_mask_q <= cfg_wdata_i[`MSI_MASK_W-1:0];
                end
            endcase
        end
    end

    assign msiptp_ppn_o = msiptp_ppn_q;
    assign addr_mask_o  = addr_mask_q;

endmodule

// ==== hdl/pte_chk_if.sv ====
`timescale 1ns/1ps

interface pte_chk_if
    import msi_ptw_pkg::*;
();

    // Beat under test and its response
    msi_pte_flat_t  pte;
    axi_resp_e      resp;

    // Verdict from the checker
    logic           fault;
    msi_cause_e     cause;

    // Walker side
    modport fsm (output pte, output resp, input fault, input cause);

    // Checker side
    modport chk (input pte, input resp, output fault, output cause);

endinterface

// ==== hdl/msi_ptw_pkg.sv ====
`include "msi_ptw_params.svh"

package msi_ptw_pkg;

    // First 64-bit beat of a flat-mode MSI PTE
    typedef struct packed {
        logic                   c;
        logic [8:0]             rsv_hi;
        logic [`MSI_PPNW-1:0]   ppn;
        logic [6:0]             rsv_lo;
        logic [1:0]             m;
        logic                   v;
    } msi_pte_flat_t;

    // PTE mode field, 0 and 2 are reserved
    typedef enum logic [1:0] {
        MODE_MRIF = 2'd1,
        MODE_FLAT = 2'd3
    } msi_mode_e;

    // Fault causes reported to the translation logic
    typedef enum logic [`MSI_CAUSE_W-1:0] {
        CAUSE_NONE          = 12'd0,
        CAUSE_INSTR_ACCESS  = 12'd1,
        CAUSE_PTE_INVALID   = 12'd262,
        CAUSE_PTE_MISCONFIG = 12'd263,
        CAUSE_DATA_CORRUPT  = 12'd270
    } msi_cause_e;

    // AXI read response codes
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'd0,
        RESP_EXOKAY = 2'd1,
        RESP_SLVERR = 2'd2,
        RESP_DECERR = 2'd3
    } axi_resp_e;

    // Config register select
    typedef enum logic {
        CFG_MSIPTP    = 1'b0,
        CFG_ADDR_MASK = 1'b1
    } cfg_sel_e;

    // Walker states
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_MEM_ACCESS,
        ST_PROC_PTE,
        ST_DRAIN,
        ST_ERROR
    } walk_state_e;

endpackage

// ==== hdl/msi_ptw_params.svh ====
`ifndef MSI_PTW_PARAMS_SVH
`define MSI_PTW_PARAMS_SVH

// Address widths
`define MSI_PLEN        56
`define MSI_GPLEN       41
`define MSI_GPPNW       29
`define MSI_PPNW        44

// Guest page number mask, one bit per GPPN bit
`define MSI_MASK_W      29

// Tags and fault reporting
`define MSI_GSCID_W     16
`define MSI_CAUSE_W     12

// Read channel beat
`define MSI_DATA_W      64

// Byte offsets
`define MSI_PTE_SHIFT   4
`define MSI_PAGE_SHIFT  12

`endif
